// File: cu_settings.svh
`ifndef CU_SETTINGS_SVH
`define CU_SETTINGS_SVH

// datapath and instruction word
`define CU_XLEN        64
`define CU_INST_W      32
`define CU_REG_ADDR_W  5
`define CU_OPCODE_W    7

// control field widths
`define CU_ALU_OP_W    5
`define CU_ALU_SRC_W   3
`define CU_REGS_SRC_W  4
`define CU_PC_SRC_W    2
`define CU_MEM_OP_W    4
`define CU_MEM_SRC_W   3   // shared by address and data selects

// comparator interface
`define CU_CMP_SRC_W   2
`define CU_CMP_RES_W   2

// internal decode fields
`define CU_IMM_FMT_W   3
`define CU_BR_COND_W   3

`endif

// File: cu_pkg.sv
`include "cu_settings.svh"

package cu_pkg;

    typedef enum logic [`CU_ALU_OP_W-1:0] {
        alu_none    = 5'b00000,
        alu_add     = 5'b00001,
        alu_add_clr = 5'b00010,   // add, clear bit 0
        alu_sll     = 5'b00011,
        alu_addw    = 5'b00100,
        alu_sub     = 5'b00101,
        alu_srai    = 5'b00110,
        alu_and     = 5'b00111,
        alu_sllw    = 5'b01000,
        alu_xor     = 5'b01001,
        alu_or      = 5'b01010,
        alu_srl     = 5'b01011,
        alu_subw    = 5'b11001,
        alu_slliw   = 5'b11010,
        alu_sraiw   = 5'b11011,
        alu_sraw    = 5'b11100,
        alu_srliw   = 5'b11101,
        alu_srlw    = 5'b11110
    } alu_op_e;

    // first operand / second operand
    typedef enum logic [`CU_ALU_SRC_W-1:0] {
        src_rs1_rs2, src_rs1_imm, src_rs1_pc,
        src_rs1_snpc, src_imm_pc, src_imm_snpc
    } alu_src_e;

    typedef enum logic [`CU_REGS_SRC_W-1:0] {
        regs_keep, regs_alu, regs_pc, regs_snpc,
        regs_imm, regs_mem, regs_zero, regs_one
    } regs_src_e;

    typedef enum logic [`CU_PC_SRC_W-1:0] {
        pc_snpc, pc_alu
    } pc_src_e;

    typedef enum logic [`CU_MEM_OP_W-1:0] {
        mem_none, mem_ld, mem_lw, mem_lh, mem_lb, mem_lwu,
        mem_lhu, mem_lbu, mem_sd, mem_sw, mem_sh, mem_sb
    } mem_op_e;

    typedef enum logic [`CU_MEM_SRC_W-1:0] {
        addr_none = 3'b000,
        addr_alu  = 3'b001
    } mem_addr_src_e;

    typedef enum logic [`CU_MEM_SRC_W-1:0] {
        data_none = 3'b000,
        data_rs2  = 3'b010
    } mem_data_src_e;

    typedef enum logic [`CU_CMP_SRC_W-1:0] {
        cmp_rs2, cmp_imm
    } cmp_src_e;

    typedef enum logic [`CU_CMP_RES_W-1:0] {
        cmp_eq = 2'b00,
        cmp_lt = 2'b01,
        cmp_gt = 2'b10
    } cmp_res_e;

    typedef enum logic [`CU_IMM_FMT_W-1:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
    } imm_fmt_e;

    typedef enum logic [`CU_BR_COND_W-1:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_always, br_slt
    } br_cond_e;

    typedef enum logic [`CU_OPCODE_W-1:0] {
        opc_load      = 7'b0000011,
        opc_op_imm    = 7'b0010011,
        opc_auipc     = 7'b0010111,
        opc_op_imm_32 = 7'b0011011,
        opc_store     = 7'b0100011,
        opc_op        = 7'b0110011,
        opc_lui       = 7'b0110111,
        opc_op_32     = 7'b0111011,
        opc_branch    = 7'b1100011,
        opc_jalr      = 7'b1100111,
        opc_jal       = 7'b1101111
    } opcode_e;

endpackage

// File: decode_stage.sv
`timescale 1ns/1ps
`include "cu_settings.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`CU_INST_W-1:0] inst,
    input  logic                  inst_valid,
    output logic [`CU_INST_W-1:0] inst_q,
    output logic                  dec_valid
);

    // valid bit tracks the input every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
    end

    // word is only captured on a valid beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_q <= '0;
        end else if (inst_valid) begin
            inst_q <= inst;
        end
    end

endmodule

// File: op_decoder.sv
`timescale 1ns/1ps
`include "cu_settings.svh"

module op_decoder
    import cu_pkg::*;
(
    input  logic [`CU_INST_W-1:0] inst_q,
    input  logic                  dec_valid,
    output alu_op_e               ctrl_alu,
    output alu_src_e              sel_alu,
    output logic                  ctrl_cmp,
    output cmp_src_e              sel_cmp,
    output regs_src_e             regs_base,
    output mem_op_e               ctrl_mem,
    output mem_addr_src_e         sel_mem_addr,
    output mem_data_src_e         sel_mem_data,
    output imm_fmt_e              imm_fmt,
    output br_cond_e              br_cond,
    output logic                  illegal_inst
);

    logic [6:0]              funct7;
    logic [2:0]              funct3;
    logic [`CU_OPCODE_W-1:0] opcode;

    assign funct7 = inst_q[31:25];
    assign funct3 = inst_q[14:12];
    assign opcode = inst_q[6:0];

    always_comb begin
        ctrl_alu     = alu_none;
        sel_alu      = src_rs1_rs2;
        ctrl_cmp     = 1'b0;
        sel_cmp      = cmp_rs2;
        regs_base    = regs_keep;
        ctrl_mem     = mem_none;
        sel_mem_addr = addr_none;
        sel_mem_data = data_none;
        imm_fmt      = imm_none;
        br_cond      = br_none;
        illegal_inst = 1'b0;

        if (dec_valid) begin
            // per-instruction fields
            casez ({funct7, funct3, opcode})
                {7'b0000000, 3'b000, opc_op}:    ctrl_alu = alu_add;
                {7'b0000000, 3'b000, opc_op_32}: ctrl_alu = alu_addw;
                {7'b0100000, 3'b000, opc_op}:    ctrl_alu = alu_sub;
                {7'b0000000, 3'b001, opc_op_32}: ctrl_alu = alu_sllw;
                {7'b0000000, 3'b111, opc_op}:    ctrl_alu = alu_and;
                {7'b0000000, 3'b011, opc_op}:    br_cond  = br_slt;   // sltu
                {7'b0000000, 3'b110, opc_op}:    ctrl_alu = alu_or;
                {7'b0100000, 3'b000, opc_op_32}: ctrl_alu = alu_subw;
                {7'b0000000, 3'b010, opc_op}: begin                    // slt
                    ctrl_cmp = 1'b1;
                    br_cond  = br_slt;
                end
                {7'b0100000, 3'b101, opc_op_32}: ctrl_alu = alu_sraw;
                {7'b0000000, 3'b101, opc_op_32}: ctrl_alu = alu_srlw;
                {7'b0000000, 3'b100, opc_op}:    ctrl_alu = alu_xor;
                {7'b0000000, 3'b001, opc_op}:    ctrl_alu = alu_sll;

                {7'b???????, 3'b000, opc_op_imm}: ctrl_alu = alu_add;
                {7'b???????, 3'b000, opc_jalr}: begin
                    ctrl_alu = alu_add_clr;
                    br_cond  = br_always;
                end
                {7'b000000?, 3'b001, opc_op_imm}: ctrl_alu = alu_sll;    // slli
                {7'b???????, 3'b010, opc_load}:   ctrl_mem = mem_lw;
                {7'b???????, 3'b011, opc_op_imm}: begin                 // sltiu
                    sel_cmp = cmp_imm;
                    br_cond = br_slt;
                end
                {7'b???????, 3'b010, opc_op_imm}: begin                 // slti
                    ctrl_cmp = 1'b1;
                    sel_cmp  = cmp_imm;
                    br_cond  = br_slt;
                end
                {7'b???????, 3'b000, opc_op_imm_32}: ctrl_alu = alu_addw;
                {7'b???????, 3'b011, opc_load}:      ctrl_mem = mem_ld;
                {7'b010000?, 3'b101, opc_op_imm}:    ctrl_alu = alu_srai;
                {7'b???????, 3'b100, opc_load}:      ctrl_mem = mem_lbu;
                {7'b???????, 3'b111, opc_op_imm}:    ctrl_alu = alu_and;
                {7'b???????, 3'b100, opc_op_imm}:    ctrl_alu = alu_xor;
                {7'b000000?, 3'b101, opc_op_imm}:    ctrl_alu = alu_srl;
                {7'b???????, 3'b001, opc_load}:      ctrl_mem = mem_lh;
                {7'b???????, 3'b101, opc_load}:      ctrl_mem = mem_lhu;
                {7'b000000?, 3'b001, opc_op_imm_32}: ctrl_alu = alu_slliw;
                {7'b010000?, 3'b101, opc_op_imm_32}: ctrl_alu = alu_sraiw;
                {7'b000000?, 3'b101, opc_op_imm_32}: ctrl_alu = alu_srliw;
                {7'b???????, 3'b110, opc_load}:      ctrl_mem = mem_lwu;
                {7'b???????, 3'b110, opc_op_imm}:    ctrl_alu = alu_or;
                {7'b???????, 3'b000, opc_load}:      ctrl_mem = mem_lb;

                {7'b???????, 3'b011, opc_store}: ctrl_mem = mem_sd;
                {7'b???????, 3'b001, opc_store}: ctrl_mem = mem_sh;
                {7'b???????, 3'b000, opc_store}: ctrl_mem = mem_sb;
                {7'b???????, 3'b010, opc_store}: ctrl_mem = mem_sw;

                {7'b???????, 3'b000, opc_branch}: br_cond = br_eq;
                {7'b???????, 3'b001, opc_branch}: br_cond = br_ne;
                {7'b???????, 3'b101, opc_branch}: begin                 // bge
                    ctrl_cmp = 1'b1;
                    br_cond  = br_ge;
                end
                {7'b???????, 3'b111, opc_branch}: br_cond = br_ge;      // bgeu
                {7'b???????, 3'b110, opc_branch}: br_cond = br_lt;      // bltu
                {7'b???????, 3'b100, opc_branch}: begin                 // blt
                    ctrl_cmp = 1'b1;
                    br_cond  = br_lt;
                end

                {10'b??????????, opc_auipc}: ctrl_alu = alu_add;
                {10'b??????????, opc_lui}:   ctrl_alu = alu_none;
                {10'b??????????, opc_jal}: begin
                    ctrl_alu = alu_add;
                    br_cond  = br_always;
                end
                default: illegal_inst = 1'b1;   // M, system, unknown
            endcase

            // fields shared by a whole opcode class
            if (!illegal_inst) begin
                case (opcode)
                    opc_op, opc_op_32: begin
                        regs_base = regs_alu;
                    end
                    opc_op_imm, opc_op_imm_32: begin
                        sel_alu   = (br_cond == br_slt) ? src_rs1_rs2 : src_rs1_imm;
                        regs_base = regs_alu;
                        imm_fmt   = imm_i;
                    end
                    opc_load: begin
                        ctrl_alu     = alu_add;
                        sel_alu      = src_rs1_imm;
                        regs_base    = regs_mem;
                        sel_mem_addr = addr_alu;
                        imm_fmt      = imm_i;
                    end
                    opc_store: begin
                        ctrl_alu     = alu_add;
                        sel_alu      = src_rs1_imm;
                        sel_mem_addr = addr_alu;
                        sel_mem_data = data_rs2;
                        imm_fmt      = imm_s;
                    end
                    opc_branch: begin
                        ctrl_alu = alu_add;
                        sel_alu  = src_imm_pc;   // target = pc + imm
                        imm_fmt  = imm_b;
                    end
                    opc_jalr: begin
                        sel_alu   = src_rs1_imm;
                        regs_base = regs_snpc;   // link
                        imm_fmt   = imm_i;
                    end
                    opc_jal: begin
                        sel_alu   = src_imm_pc;
                        regs_base = regs_snpc;
                        imm_fmt   = imm_j;
                    end
                    opc_lui: begin
                        regs_base = regs_imm;
                        imm_fmt   = imm_u;
                    end
                    opc_auipc: begin
                        sel_alu   = src_imm_pc;
                        regs_base = regs_alu;
                        imm_fmt   = imm_u;
                    end
                    default: begin
                        regs_base = regs_keep;
                    end
                endcase
            end
        end
    end

endmodule

// File: imm_gen.sv
`timescale 1ns/1ps
`include "cu_settings.svh"

module imm_gen
    import cu_pkg::*;
(
    input  logic [`CU_INST_W-1:0] inst_q,
    input  imm_fmt_e              imm_fmt,
    output logic [`CU_XLEN-1:0]   imm
);

    logic sign;

    assign sign = inst_q[31];

    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{(`CU_XLEN-12){sign}}, inst_q[31:20]};
            end
            imm_s: begin
                imm = {{(`CU_XLEN-12){sign}}, inst_q[31:25], inst_q[11:7]};
            end
            imm_b: begin   // bit 0 always zero
                imm = {{(`CU_XLEN-12){sign}}, inst_q[7], inst_q[30:25],
                       inst_q[11:8], 1'b0};
            end
            imm_u: begin
                imm = {{(`CU_XLEN-32){sign}}, inst_q[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{(`CU_XLEN-20){sign}}, inst_q[19:12], inst_q[20],
                       inst_q[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve
    import cu_pkg::*;
(
    input  br_cond_e  br_cond,
    input  regs_src_e regs_base,
    input  cmp_res_e  cmp_out,
    output pc_src_e   sel_pc,
    output regs_src_e sel_regs
);

    logic is_eq;
    logic is_lt;
    logic is_gt;

    assign is_eq = (cmp_out == cmp_eq);
    assign is_lt = (cmp_out == cmp_lt);
    assign is_gt = (cmp_out == cmp_gt);

    always_comb begin
        sel_pc   = pc_snpc;
        sel_regs = regs_base;
        case (br_cond)
            br_eq: begin
                sel_pc = is_eq ? pc_alu : pc_snpc;
            end
            br_ne: begin
                sel_pc = is_eq ? pc_snpc : pc_alu;
            end
            br_lt: begin
                sel_pc = is_lt ? pc_alu : pc_snpc;
            end
            br_ge: begin
                sel_pc = (is_eq || is_gt) ? pc_alu : pc_snpc;
            end
            br_always: begin   // jal, jalr
                sel_pc = pc_alu;
            end
            br_slt: begin      // write 1 or 0 to rd
                sel_regs = is_lt ? regs_one : regs_zero;
            end
            default: begin
                sel_pc = pc_snpc;
            end
        endcase
    end

endmodule

// File: cu_top.sv
`timescale 1ns/1ps
`include "cu_settings.svh"

module cu_top
    import cu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CU_INST_W-1:0]     inst,
    input  logic                      inst_valid,
    input  cmp_res_e                  cmp_out,
    output logic [`CU_REG_ADDR_W-1:0] rs1,
    output logic [`CU_REG_ADDR_W-1:0] rs2,
    output logic [`CU_REG_ADDR_W-1:0] rd,
    output logic [`CU_XLEN-1:0]       imm,
    output alu_op_e                   ctrl_alu,
    output alu_src_e                  sel_alu,
    output logic                      ctrl_cmp,
    output cmp_src_e                  sel_cmp,
    output regs_src_e                 sel_regs,
    output pc_src_e                   sel_pc,
    output mem_op_e                   ctrl_mem,
    output mem_addr_src_e             sel_mem_addr,
    output mem_data_src_e             sel_mem_data,
    output logic                      dec_valid,
    output logic                      illegal_inst
);

    logic [`CU_INST_W-1:0] inst_q;
    regs_src_e             regs_base;
    imm_fmt_e              imm_fmt;
    br_cond_e              br_cond;

    assign rs1 = inst_q[19:15];
    assign rs2 = inst_q[24:20];
    assign rd  = inst_q[11:7];

    decode_stage u_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_q     (inst_q),
        .dec_valid  (dec_valid)
    );

    op_decoder u_op_decoder (
        .inst_q       (inst_q),
        .dec_valid    (dec_valid),
        .ctrl_alu     (ctrl_alu),
        .sel_alu      (sel_alu),
        .ctrl_cmp     (ctrl_cmp),
        .sel_cmp      (sel_cmp),
        .regs_base    (regs_base),
        .ctrl_mem     (ctrl_mem),
        .sel_mem_addr (sel_mem_addr),
        .sel_mem_data (sel_mem_data),
        .imm_fmt      (imm_fmt),
        .br_cond      (br_cond),
        .illegal_inst (illegal_inst)
    );

    imm_gen u_imm_gen (
        .inst_q  (inst_q),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // cmp_out arrives from the external comparator in the decode cycle
    branch_resolve u_branch_resolve (
        .br_cond   (br_cond),
        .regs_base (regs_base),
        .cmp_out   (cmp_out),
        .sel_pc    (sel_pc),
        .sel_regs  (sel_regs)
    );

endmodule

// File: cu_sva.sv
`timescale 1ns/1ps

module cu_sva
    import cu_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    inst_valid,
    input logic    dec_valid,
    input logic    illegal_inst,
    input mem_op_e ctrl_mem,
    input pc_src_e sel_pc
);

    // no memory access or redirect without a decoded word
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !dec_valid |-> (ctrl_mem == mem_none && sel_pc == pc_snpc))
        else $error("memory op or pc redirect active while dec_valid is low");

    illegal_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_inst |-> dec_valid)
        else $error("illegal_inst raised without dec_valid");

    valid_follows_input: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid == $past(inst_valid))   // one stage of latency
        else $error("dec_valid does not follow inst_valid of the previous cycle");

endmodule

bind cu_top cu_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .dec_valid    (dec_valid),
    .illegal_inst (illegal_inst),
    .ctrl_mem     (ctrl_mem),
    .sel_pc       (sel_pc)
);

// File: cu_tb.sv
`timescale 1ns/1ps
`include "cu_settings.svh"

module cu_tb
    import cu_pkg::*;
();

    localparam int NF        = 13;   // fields per golden line
    localparam int MAX_TESTS = 64;

    logic                      clk;
    logic                      rst_n;
    logic [`CU_INST_W-1:0]     inst;
    logic                      inst_valid;
    cmp_res_e                  cmp_out;
    logic [`CU_REG_ADDR_W-1:0] rs1;
    logic [`CU_REG_ADDR_W-1:0] rs2;
    logic [`CU_REG_ADDR_W-1:0] rd;
    logic [`CU_XLEN-1:0]       imm;
    alu_op_e                   ctrl_alu;
    alu_src_e                  sel_alu;
    logic                      ctrl_cmp;
    cmp_src_e                  sel_cmp;
    regs_src_e                 sel_regs;
    pc_src_e                   sel_pc;
    mem_op_e                   ctrl_mem;
    mem_addr_src_e             sel_mem_addr;
    mem_data_src_e             sel_mem_data;
    logic                      dec_valid;
    logic                      illegal_inst;

    logic [63:0] rows [0:MAX_TESTS-1][0:NF-1];
    logic [63:0] actual [2:NF-1];   // same order as the golden columns
    string       names [2:NF-1];
    int          n_tests;
    int          errors;
    int          failed_tests;
    int          cycles;
    int          limit;
    logic [31:0] lfsr;

    cu_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .cmp_out      (cmp_out),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .ctrl_alu     (ctrl_alu),
        .sel_alu      (sel_alu),
        .ctrl_cmp     (ctrl_cmp),
        .sel_cmp      (sel_cmp),
        .sel_regs     (sel_regs),
        .sel_pc       (sel_pc),
        .ctrl_mem     (ctrl_mem),
        .sel_mem_addr (sel_mem_addr),
        .sel_mem_data (sel_mem_data),
        .dec_valid    (dec_valid),
        .illegal_inst (illegal_inst)
    );

    assign actual[2]  = imm;
    assign actual[3]  = 64'(ctrl_alu);
    assign actual[4]  = 64'(sel_alu);
    assign actual[5]  = 64'(ctrl_cmp);
    assign actual[6]  = 64'(sel_cmp);
    assign actual[7]  = 64'(sel_regs);
    assign actual[8]  = 64'(sel_pc);
    assign actual[9]  = 64'(ctrl_mem);
    assign actual[10] = 64'(sel_mem_addr);
    assign actual[11] = 64'(sel_mem_data);
    assign actual[12] = 64'(illegal_inst);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_decoded(input int t);
        logic [31:0] word;
        word = rows[t][0][31:0];
        check_value("dec_valid", 64'(dec_valid), 64'd1);
        check_value("rs1", 64'(rs1), 64'(word[19:15]));
        check_value("rs2", 64'(rs2), 64'(word[24:20]));
        check_value("rd", 64'(rd), 64'(word[11:7]));
        for (int i = 2; i < NF; i++) begin
            check_value(names[i], actual[i], rows[t][i]);
        end
    endtask

    // every inactive encoding is zero
    task automatic check_idle();
        check_value("dec_valid", 64'(dec_valid), 64'd0);
        for (int i = 2; i < NF; i++) begin
            check_value(names[i], actual[i], 64'd0);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          gap;
        int          start_err;
        string       line;
        logic [63:0] f [0:NF-1];

        rst_n        = 1'b0;
        inst         = '0;
        inst_valid   = 1'b0;
        cmp_out      = cmp_eq;
        errors       = 0;
        failed_tests = 0;
        n_tests      = 0;
        cycles       = 0;
        limit        = 20;
        lfsr         = 32'hd8ad;
        names = '{"imm", "ctrl_alu", "sel_alu", "ctrl_cmp", "sel_cmp", "sel_regs",
                  "sel_pc", "ctrl_mem", "sel_mem_addr", "sel_mem_data", "illegal_inst"};

        fd = $fopen("cu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open cu_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() == 0 || line.getc(0) == "#") continue;   // header lines
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                            f[7], f[8], f[9], f[10], f[11], f[12]);
                if (n <= 0) continue;
                if (n != NF) begin
                    $display("golden line could not be parsed: %s", line);
                    errors++;
                end else begin
                    for (int i = 0; i < NF; i++) begin
                        rows[n_tests][i] = f[i];
                    end
                    n_tests++;
                end
            end
            $fclose(fd);
            if (n_tests == 0) begin
                $display("the golden file holds no tests");
                errors++;
            end
        end
        limit = n_tests * 6 + 20;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        start_err = errors;
        check_idle();
        $display("after reset: %s", (errors == start_err) ? "ok" : "FAILED");

        for (int t = 0; t < n_tests; t++) begin
            start_err = errors;
            @(posedge clk);
            inst       <= rows[t][0][31:0];
            inst_valid <= 1'b1;
            @(posedge clk);
            inst_valid <= 1'b0;
            cmp_out    <= cmp_res_e'(rows[t][1][1:0]);   // comparator answers in decode cycle
            @(negedge clk);
            check_decoded(t);
            draw_bits(2, gap);
            repeat (gap) begin
                @(posedge clk);
                @(negedge clk);
                check_idle();
            end
            if (errors != start_err) failed_tests++;
            $display("test %0d inst %h cmp %0d: %s", t, rows[t][0][31:0], rows[t][1][1:0],
                     (errors == start_err) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, check errors %0d", n_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: cu_golden.txt
# inst cmp_out imm ctrl_alu sel_alu ctrl_cmp sel_cmp sel_regs sel_pc ctrl_mem mem_addr mem_data illegal
# all columns hex, one test per line
002081b3 0 0000000000000000 01 0 0 0 1 0 0 0 0 0
407302b3 0 0000000000000000 05 0 0 0 1 0 0 0 0 0
40c5d53b 0 0000000000000000 1c 0 0 0 1 0 0 0 0 0
ffb10093 0 fffffffffffffffb 01 1 0 0 1 0 0 0 0 0
1232821b 0 0000000000000123 04 1 0 0 1 0 0 0 0 0
42145393 0 0000000000000421 06 1 0 0 1 0 0 0 0 0
0035549b 0 0000000000000003 1d 1 0 0 1 0 0 0 0 0
01013303 0 0000000000000010 01 1 0 0 5 0 1 1 0 0
fff1c383 0 ffffffffffffffff 01 1 0 0 5 0 7 1 0 0
fe532623 0 ffffffffffffffec 01 1 0 0 0 0 9 1 2 0
02813423 0 0000000000000028 01 1 0 0 0 0 8 1 2 0
00208863 0 0000000000000010 01 4 0 0 0 1 0 0 0 0
00208863 1 0000000000000010 01 4 0 0 0 0 0 0 0 0
00208863 2 0000000000000010 01 4 0 0 0 0 0 0 0 0
fe209ce3 2 fffffffffffffff8 01 4 0 0 0 1 0 0 0 0
0241c063 1 0000000000000020 01 4 1 0 0 1 0 0 0 0
0241d063 0 0000000000000020 01 4 1 0 0 1 0 0 0 0
0241e063 2 0000000000000020 01 4 0 0 0 0 0 0 0 0
0241f063 1 0000000000000020 01 4 0 0 0 0 0 0 0 0
ffdff0ef 2 fffffffffffffffc 01 4 0 0 3 1 0 0 0 0
00c280e7 0 000000000000000c 02 1 0 0 3 1 0 0 0 0
abcde3b7 1 ffffffffabcde000 00 0 0 0 4 0 0 0 0 0
00001497 0 0000000000001000 01 4 0 0 1 0 0 0 0 0
0020a1b3 1 0000000000000000 00 0 1 0 7 0 0 0 0 0
0020b1b3 2 0000000000000000 00 0 0 0 6 0 0 0 0 0
fff2a213 1 ffffffffffffffff 00 0 1 1 7 0 0 0 0 0
0642b213 0 0000000000000064 00 0 0 1 6 0 0 0 0 0
00000073 0 0000000000000000 00 0 0 0 0 0 0 0 0 1
022081b3 1 0000000000000000 00 0 0 0 0 0 0 0 0 1
00000000 2 0000000000000000 00 0 0 0 0 0 0 0 0 1

// File: build.f
+incdir+.
cu_pkg.sv
decode_stage.sv
op_decoder.sv
imm_gen.sv
branch_resolve.sv
cu_top.sv
cu_sva.sv
cu_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the decode control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module cu_tb -f build.f -o cu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/cu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1
